/* list.f */
logic/aluPkg.sv
logic/claBlock4.sv
logic/claAdder32.sv
logic/alu.sv
logic/branchCompare.sv
logic/executeReg.sv
logic/executeUnit.sv
sim/executeUnitTb.sv

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire  [aluPkg::xlen-1:0]       operandA,
    input  wire  [aluPkg::xlen-1:0]       operandB,
    input  wire  [aluPkg::aluOpWidth-1:0] aluOp,
    output logic [aluPkg::xlen-1:0]       result,
    output logic                          carry,
    output logic                          overflow,
    output logic                          zero
);

    import aluPkg::*;

    logic [xlen-1:0]       adderSum;
    logic                  subtract;
    logic [shamtWidth-1:0] shamt;
    logic                  lessSigned;
    logic                  lessUnsigned;

    // Compares share the subtract path
    assign subtract = (aluOp == opSub) || (aluOp == opSlt) || (aluOp == opSltu);

    claAdder32 u_claAdder32 (
        .a        (operandA),
        .b        (operandB),
        .subtract (subtract),
        .sum      (adderSum),
        .carry    (carry),
        .overflow (overflow)
    );

    assign shamt = operandB[shamtWidth-1:0];

    // Sign corrected by overflow gives a true signed compare
    assign lessSigned   = adderSum[xlen-1] ^ overflow;
    assign lessUnsigned = carry;               // Borrow out of a - b

    always_comb begin
        case (aluOp)
            opAdd, opSub: result = adderSum;
            opAnd:        result = operandA & operandB;
            opOr:         result = operandA | operandB;
            opXor:        result = operandA ^ operandB;
            opSll:        result = operandA << shamt;
            opSrl:        result = operandA >> shamt;
            opSra:        result = $unsigned($signed(operandA) >>> shamt);   // Sign fill
            opSlt: begin
                result = '0;
                result[0] = lessSigned;
            end
            opSltu: begin
                result = '0;
                result[0] = lessUnsigned;
            end
            default:      result = '0;         // Undefined op codes
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/aluPkg.sv */
`default_nettype none

package aluPkg;

    // Datapath width
    localparam int xlen = 32;
    localparam int shamtWidth = 5;   // Low bits of operand B used by shifts

    localparam int aluOpWidth = 4;

    // ALU op codes
    localparam logic [aluOpWidth-1:0] opAnd  = 4'b0000;
    localparam logic [aluOpWidth-1:0] opOr   = 4'b0001;
    localparam logic [aluOpWidth-1:0] opAdd  = 4'b0010;
    localparam logic [aluOpWidth-1:0] opXor  = 4'b0011;
    localparam logic [aluOpWidth-1:0] opSll  = 4'b0100;
    localparam logic [aluOpWidth-1:0] opSrl  = 4'b0101;
    localparam logic [aluOpWidth-1:0] opSub  = 4'b0110;
    localparam logic [aluOpWidth-1:0] opSra  = 4'b0111;
    localparam logic [aluOpWidth-1:0] opSlt  = 4'b1000;
    localparam logic [aluOpWidth-1:0] opSltu = 4'b1001;

    localparam int branchCondWidth = 3;

    // Branch conditions as RISC-V funct3 values
    localparam logic [branchCondWidth-1:0] condEq  = 3'b000;
    localparam logic [branchCondWidth-1:0] condNe  = 3'b001;
    localparam logic [branchCondWidth-1:0] condLt  = 3'b100;
    localparam logic [branchCondWidth-1:0] condGe  = 3'b101;
    localparam logic [branchCondWidth-1:0] condLtu = 3'b110;
    localparam logic [branchCondWidth-1:0] condGeu = 3'b111;

endpackage

`default_nettype wire

/* logic/branchCompare.sv */
`timescale 1ns/1ns
`default_nettype none

module branchCompare (
    input  wire                               isBranch,
    input  wire  [aluPkg::branchCondWidth-1:0] branchCond,
    input  wire                               carry,      // Borrow from the SUB
    input  wire                               overflow,
    input  wire                               zero,
    input  wire                               negative,
    output logic                              taken
);

    import aluPkg::*;

    logic condMet;
    logic lessSigned;

    // Flags come from a - b
    assign lessSigned = negative ^ overflow;

    always_comb begin
        case (branchCond)
            condEq:  condMet = zero;
            condNe:  condMet = ~zero;
            condLt:  condMet = lessSigned;
            condGe:  condMet = ~lessSigned;
            condLtu: condMet = carry;
            condGeu: condMet = ~carry;
            default: condMet = 1'b0;           // Reserved funct3 values
        endcase
    end

    assign taken = isBranch & condMet;

endmodule

`default_nettype wire

/* logic/claAdder32.sv */
`timescale 1ns/1ns
`default_nettype none

module claAdder32 (
    input  wire  [aluPkg::xlen-1:0] a,
    input  wire  [aluPkg::xlen-1:0] b,
    input  wire                     subtract,   // High for a - b
    output logic [aluPkg::xlen-1:0] sum,
    output logic                    carry,
    output logic                    overflow
);

    import aluPkg::*;

    localparam int numBlocks = xlen / 4;

    logic [xlen-1:0]      bMod;          // b or its ones complement
    logic [numBlocks:0]   blockCarry;
    logic                 carryIntoTop;  // Carry into the sign bit

    assign bMod = b ^ {xlen{subtract}};
    assign blockCarry[0] = subtract;     // Plus one completes the twos complement

    for (genvar i = 0; i < numBlocks; i++) begin : genBlock
        claBlock4 u_claBlock4 (
            .a        (a[4*i +: 4]),
            .b        (bMod[4*i +: 4]),
            .carryIn  (blockCarry[i]),
            .sum      (sum[4*i +: 4]),
            .carryOut (blockCarry[i+1])
        );
    end

    // Sum bit is a ^ b ^ c, so the carry into bit 31 falls out of it
    assign carryIntoTop = sum[xlen-1] ^ a[xlen-1] ^ bMod[xlen-1];
    assign overflow = carryIntoTop ^ blockCarry[numBlocks];

    // Reads as a borrow when subtracting
    assign carry = blockCarry[numBlocks] ^ subtract;

endmodule

`default_nettype wire

/* logic/claBlock4.sv */
`timescale 1ns/1ns
`default_nettype none

module claBlock4 (
    input  wire  [3:0] a,
    input  wire  [3:0] b,
    input  wire        carryIn,
    output logic [3:0] sum,
    output logic       carryOut
);

    logic [3:0] g;   // Generate
    logic [3:0] p;   // Propagate
    logic [3:0] c;   // Carry into each bit

    assign g = a & b;
    assign p = a ^ b;

    // Flat two-level lookahead with no ripple inside the block
    assign c[0] = carryIn;
    assign c[1] = g[0] | (p[0] & carryIn);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carryIn);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & carryIn);
    assign carryOut = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                    | (p[3] & p[2] & p[1] & g[0])
                    | (p[3] & p[2] & p[1] & p[0] & carryIn);

    assign sum = p ^ c;

endmodule

`default_nettype wire

/* logic/executeReg.sv */
`timescale 1ns/1ns
`default_nettype none

module executeReg (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     valid,
    input  wire                     flush,
    input  wire  [aluPkg::xlen-1:0] aluResult,
    input  wire                     carry,
    input  wire                     overflow,
    input  wire                     zero,
    input  wire                     taken,
    output logic [aluPkg::xlen-1:0] result,
    output logic                    carryOut,
    output logic                    overflowOut,
    output logic                    zeroOut,
    output logic                    branchTaken,
    output logic                    resultValid
);

    import aluPkg::*;

    logic keep;   // Item survives into the next stage

    assign keep = valid & ~flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            result      <= {xlen{1'b0}};
            carryOut    <= 1'b0;
            overflowOut <= 1'b0;
            zeroOut     <= 1'b0;
            branchTaken <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            // Data loads every cycle, flush or not
            result      <= aluResult;
            carryOut    <= carry;
            overflowOut <= overflow;
            zeroOut     <= zero;
            branchTaken <= keep & taken;
            resultValid <= keep;
        end
    end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               valid,
    input  wire                               flush,
    input  wire  [aluPkg::aluOpWidth-1:0]      aluOp,
    input  wire  [aluPkg::xlen-1:0]            operandA,
    input  wire  [aluPkg::xlen-1:0]            operandB,
    input  wire                               isBranch,
    input  wire  [aluPkg::branchCondWidth-1:0] branchCond,
    output logic [aluPkg::xlen-1:0]            result,
    output logic                              carryOut,
    output logic                              overflowOut,
    output logic                              zeroOut,
    output logic                              branchTaken,
    output logic                              resultValid
);

    import aluPkg::*;

    logic [xlen-1:0] aluResult;
    logic            carry;
    logic            overflow;
    logic            zero;
    logic            taken;

    alu u_alu (
        .operandA (operandA),
        .operandB (operandB),
        .aluOp    (aluOp),
        .result   (aluResult),
        .carry    (carry),
        .overflow (overflow),
        .zero     (zero)
    );

    // Branches issue as SUB, so the ALU flags describe a - b
    branchCompare u_branchCompare (
        .isBranch   (isBranch),
        .branchCond (branchCond),
        .carry      (carry),
        .overflow   (overflow),
        .zero       (zero),
        .negative   (aluResult[xlen-1]),
        .taken      (taken)
    );

    executeReg u_executeReg (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .flush       (flush),
        .aluResult   (aluResult),
        .carry       (carry),
        .overflow    (overflow),
        .zero        (zero),
        .taken       (taken),
        .result      (result),
        .carryOut    (carryOut),
        .overflowOut (overflowOut),
        .zeroOut     (zeroOut),
        .branchTaken (branchTaken),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f list.f \
    --top-module executeUnitTb -o executeUnitSim
./obj_dir/executeUnitSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* sim/executeUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module executeUnitTb;

    import aluPkg::*;

    localparam int resetCycles = 10;
    localparam int randomPairs = 50;
    // One cycle per issued operation
    localparam int testCycles = resetCycles + 2
        + 2 * (16 + randomPairs)   // Arithmetic
        + 10 * 6 + 6 + 6           // Logic, shifts, undefined ops
        + 2 * (6 + 30)             // Compares
        + 6 * 8 * 2                // Branches
        + 11;                      // Pipeline and flush
    localparam int timeoutCycles = testCycles + 200;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       valid;
    logic                       flush;
    logic [aluOpWidth-1:0]      aluOp;
    logic [xlen-1:0]            operandA;
    logic [xlen-1:0]            operandB;
    logic                       isBranch;
    logic [branchCondWidth-1:0] branchCond;
    logic [xlen-1:0]            result;
    logic                       carryOut;
    logic                       overflowOut;
    logic                       zeroOut;
    logic                       branchTaken;
    logic                       resultValid;

    int checkCount = 0;
    int errorCount = 0;
    int cycleCount = 0;

    executeUnit u_executeUnit (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .flush       (flush),
        .aluOp       (aluOp),
        .operandA    (operandA),
        .operandB    (operandB),
        .isBranch    (isBranch),
        .branchCond  (branchCond),
        .result      (result),
        .carryOut    (carryOut),
        .overflowOut (overflowOut),
        .zeroOut     (zeroOut),
        .branchTaken (branchTaken),
        .resultValid (resultValid)
    );

    always #20 clk = ~clk;   // 40 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Run stopped after %0d cycles with tests still running", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Expected result and flags from the operator definitions
    function automatic void aluModel(input logic [3:0] op, input logic [31:0] a,
                                     input logic [31:0] b, output logic [31:0] res,
                                     output logic c, output logic ov, output logic z);
        logic [32:0] wide;
        logic [31:0] s;
        if (op == opSub || op == opSlt || op == opSltu) begin
            s = a - b;
            c = (a < b);                                   // Borrow
            ov = (a[31] != b[31]) && (s[31] != a[31]);
        end else begin
            wide = {1'b0, a} + {1'b0, b};
            s = wide[31:0];
            c = wide[32];
            ov = (a[31] == b[31]) && (s[31] != a[31]);
        end
        case (op)
            opAdd, opSub: res = s;
            opAnd:        res = a & b;
            opOr:         res = a | b;
            opXor:        res = a ^ b;
            opSll:        res = a << b[4:0];
            opSrl:        res = a >> b[4:0];
            opSra:        res = 32'($signed(a) >>> b[4:0]);
            opSlt:        res = {31'd0, $signed(a) < $signed(b)};
            opSltu:       res = {31'd0, a < b};
            default:      res = '0;
        endcase
        z = (res == '0);
    endfunction

    function automatic logic branchModel(input logic br, input logic [2:0] cond,
                                         input logic [31:0] a, input logic [31:0] b);
        logic met;
        case (cond)
            condEq:  met = (a == b);
            condNe:  met = (a != b);
            condLt:  met = ($signed(a) < $signed(b));
            condGe:  met = ($signed(a) >= $signed(b));
            condLtu: met = (a < b);
            condGeu: met = (a >= b);
            default: met = 1'b0;
        endcase
        return br & met;
    endfunction

    // Starts on a falling edge and checks one cycle later
    task automatic issueOp(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic br, input logic [2:0] cond, input logic fl);
        logic [31:0] expRes;
        logic        expCarry;
        logic        expOverflow;
        logic        expZero;
        logic        expTaken;
        logic        expValid;
        aluModel(op, a, b, expRes, expCarry, expOverflow, expZero);
        expTaken = branchModel(br, cond, a, b) & ~fl;
        expValid = ~fl;
        valid = 1'b1;
        aluOp = op;
        operandA = a;
        operandB = b;
        isBranch = br;
        branchCond = cond;
        flush = fl;
        @(negedge clk);
        valid = 1'b0;
        isBranch = 1'b0;
        flush = 1'b0;
        checkValue("result", expRes, result);
        checkValue("carryOut", 32'(expCarry), 32'(carryOut));
        checkValue("overflowOut", 32'(expOverflow), 32'(overflowOut));
        checkValue("zeroOut", 32'(expZero), 32'(zeroOut));
        checkValue("branchTaken", 32'(expTaken), 32'(branchTaken));
        checkValue("resultValid", 32'(expValid), 32'(resultValid));
    endtask

    task automatic plainOp(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        issueOp(op, a, b, 1'b0, condEq, 1'b0);
    endtask

    task automatic idleCycle();
        @(negedge clk);
        checkValue("resultValid", 32'd0, 32'(resultValid));
        checkValue("branchTaken", 32'd0, 32'(branchTaken));
    endtask

    task automatic finishTest(input string name, input int startErrors);
        $display("%s finished with %0d errors", name, errorCount - startErrors);
    endtask

    task automatic resetBehavior();
        int startErrors;
        startErrors = errorCount;
        reset = 1'b1;
        repeat (resetCycles) begin
            @(negedge clk);
            checkValue("result", 32'd0, result);
            checkValue("resultValid", 32'd0, 32'(resultValid));
            checkValue("branchTaken", 32'd0, 32'(branchTaken));
        end
        reset = 1'b0;
        idleCycle();
        idleCycle();
        finishTest("reset state", startErrors);
    endtask

    task automatic arithmeticOps();
        logic [31:0] edgeVals [4];
        logic [31:0] a;
        logic [31:0] b;
        int          startErrors;
        startErrors = errorCount;
        edgeVals = '{32'h0, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                plainOp(opAdd, edgeVals[i], edgeVals[j]);
                plainOp(opSub, edgeVals[i], edgeVals[j]);
            end
        end
        for (int i = 0; i < randomPairs; i++) begin
            a = $urandom();
            b = $urandom();
            plainOp(opAdd, a, b);
            plainOp(opSub, a, b);
        end
        finishTest("arithmetic", startErrors);
    endtask

    task automatic logicAndShifts();
        logic [31:0] a;
        logic [31:0] b;
        int          startErrors;
        startErrors = errorCount;
        for (int i = 0; i < 10; i++) begin
            a = $urandom();
            b = $urandom();   // Upper bits of B are random too
            plainOp(opAnd, a, b);
            plainOp(opOr, a, b);
            plainOp(opXor, a, b);
            plainOp(opSll, a, b);
            plainOp(opSrl, a, b);
            plainOp(opSra, a, b);
        end
        a = $urandom() | 32'h8000_0000;   // Negative so SRA fills ones
        plainOp(opSll, a, 32'hFFFF_FFE0);   // Shift by 0
        plainOp(opSrl, a, 32'hFFFF_FFE0);
        plainOp(opSra, a, 32'hFFFF_FFE0);
        plainOp(opSll, a, 32'hFFFF_FFFF);   // Shift by 31
        plainOp(opSrl, a, 32'hFFFF_FFFF);
        plainOp(opSra, a, 32'hFFFF_FFFF);
        for (int op = 10; op < 16; op++) begin
            plainOp(4'(op), a, b);   // Undefined codes
        end
        finishTest("logic and shifts", startErrors);
    endtask

    task automatic compareOps();
        logic [31:0] pairA [6];
        logic [31:0] pairB [6];
        logic [31:0] a;
        logic [31:0] b;
        int          startErrors;
        startErrors = errorCount;
        pairA = '{32'h8000_0000, 32'h1, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000,
                  32'h1234_5678};
        pairB = '{32'h1, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h7FFF_FFFF,
                  32'h1234_5678};
        for (int i = 0; i < 6; i++) begin
            plainOp(opSlt, pairA[i], pairB[i]);
            plainOp(opSltu, pairA[i], pairB[i]);
        end
        for (int i = 0; i < 30; i++) begin
            a = $urandom();
            b = $urandom();
            plainOp(opSlt, a, b);
            plainOp(opSltu, a, b);
        end
        finishTest("compares", startErrors);
    endtask

    task automatic branchDecisions();
        logic [31:0] pairA [6];
        logic [31:0] pairB [6];
        int          startErrors;
        startErrors = errorCount;
        // Equal, less, greater, then sign and unsigned order disagreeing
        pairA = '{32'd5, 32'd3, 32'd9, 32'hFFFF_FFF0, 32'd16, 32'h8000_0000};
        pairB = '{32'd5, 32'd9, 32'd3, 32'd16, 32'hFFFF_FFF0, 32'h7FFF_FFFF};
        for (int i = 0; i < 6; i++) begin
            for (int c = 0; c < 8; c++) begin
                issueOp(opSub, pairA[i], pairB[i], 1'b1, 3'(c), 1'b0);
                issueOp(opSub, pairA[i], pairB[i], 1'b0, 3'(c), 1'b0);
            end
        end
        finishTest("branches", startErrors);
    endtask

    task automatic pipelineFlush();
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < 8; i++) begin
            plainOp(i[0] ? opXor : opAdd, $urandom(), $urandom());
        end
        issueOp(opSub, 32'd7, 32'd7, 1'b1, condEq, 1'b1);   // Killed but data still loads
        issueOp(opSub, 32'd7, 32'd7, 1'b1, condEq, 1'b0);
        idleCycle();
        finishTest("pipeline and flush", startErrors);
    endtask

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        flush = 1'b0;
        aluOp = opAdd;
        operandA = '0;
        operandB = '0;
        isBranch = 1'b0;
        branchCond = condEq;
        void'($urandom(75507));
        resetBehavior();
        arithmeticOps();
        logicAndShifts();
        compareOps();
        branchDecisions();
        pipelineFlush();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
